//--- verilog.f
hdl/xt_bus_pkg.sv
hdl/bus_decoder.sv
hdl/ems_mapper.sv
hdl/readback_mux.sv
hdl/xt_glue_top.sv
tests/tb_clock_gen.sv
tests/xt_glue_checker.sv
tests/tb_xt_glue.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the XT glue testbench with Verilator, runs it and looks for the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module tb_xt_glue; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_xt_glue)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "** PASS **" <<< "$sim_output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tests/tb_xt_glue.sv
// Testbench for the XT glue block with EMS at 260h and LPT at 378h.
// Decode and LPT timing are checked by the bound checker; EMS and LPT
// read-back values are compared here against a model of the map rules.
`timescale 1ns/1ps

module tb_xt_glue
    import xt_bus_pkg::*;
();

    localparam logic [15:0] LPT_BASE      = 16'h0378;
    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;
    localparam int          SEED          = 42199;
    localparam int          RESET_TIMEOUT = 20;

    logic                 clock;
    logic                 reset;
    addr_t                addr_i;
    data_t                data_i;
    logic                 io_read_n_i;
    logic                 io_write_n_i;
    logic                 memory_read_n_i;
    logic                 aen_n_i;
    logic                 ems_enable_i;
    logic [1:0]           ems_frame_i;
    logic [IO_SLOTS-1:0]  io_cs_n_o;
    logic                 bios_cs_n_o;
    logic                 xtide_cs_n_o;
    logic [EMS_BANKS-1:0] ems_bank_o;
    data_t                data_o;
    logic                 data_valid_o;
    data_t                lpt_data_o;

    logic [EMS_MAP_W-1:0] model_map [EMS_BANKS];
    logic [EMS_BANKS-1:0] model_ena;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (2)
    ) u_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    xt_glue_top #(
        .LPT_BASE      (LPT_BASE),
        .EMS_PORT_BASE (EMS_PORT_BASE)
    ) dut (.*);

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("** Error at %0t: %s expected %0h, got %0h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clock);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                fail_run("Reset was never released");
            end
        end
    endtask

    task automatic io_write(input logic [15:0] port, input data_t value);
        @(posedge clock);
        #1;
        addr_i          = {4'h0, port};
        data_i          = value;
        aen_n_i         = 1'b0;
        memory_read_n_i = 1'b1;
        io_write_n_i    = 1'b0;
        @(posedge clock);
        #1;
        io_write_n_i = 1'b1;
    endtask

    // Samples the read data in the middle of the strobe
    task automatic io_read(input logic [15:0] port, output data_t value, output logic valid);
        @(posedge clock);
        #1;
        addr_i          = {4'h0, port};
        aen_n_i         = 1'b0;
        memory_read_n_i = 1'b1;
        io_read_n_i     = 1'b0;
        #4;
        value = data_o;
        valid = data_valid_o;
        @(posedge clock);
        #1;
        io_read_n_i = 1'b1;
    endtask

    task automatic mem_address(input addr_t addr, input logic aen_n);
        @(posedge clock);
        #1;
        addr_i          = addr;
        aen_n_i         = aen_n;
        memory_read_n_i = 1'b0;
        #4;
    endtask

    task automatic drive_frame(input int frame);
        @(posedge clock);
        #1;
        ems_frame_i = 2'(frame);
    endtask

    task automatic set_ems_enable(input logic enable);
        @(posedge clock);
        #1;
        ems_enable_i = enable;
    endtask

    // FFh disables, below 80h maps and enables, the rest is ignored
    task automatic model_write(input int k, input data_t value);
        if (value == 8'hFF) begin
            model_map[k] = 7'h7F;
            model_ena[k] = 1'b0;
        end else if (value < 8'h80) begin
            model_map[k] = value[EMS_MAP_W-1:0];
            model_ena[k] = 1'b1;
        end
    endtask

    function automatic data_t expected_read(input int k);
        return model_ena[k] ? {1'b0, model_map[k]} : 8'hFF;
    endfunction

    function automatic data_t map_value(input int kind);
        case (kind)
            0:       return 8'hFF;
            1:       return {1'b0, 7'($urandom)};
            default: return {1'b1, 7'($urandom)};
        endcase
    endfunction

    function automatic logic [3:0] frame_nibble(input int frame);
        case (frame)
            0:       return EMS_FRAME_A;
            1:       return EMS_FRAME_C;
            default: return EMS_FRAME_D;
        endcase
    endfunction

    always @(posedge clock) begin
        if (dut.u_checker.fail_count != 0) begin
            fail_run("An assertion in the bound checker failed");
        end
    end

    initial begin
        data_t       value;
        data_t       got;
        logic        valid;
        logic [15:0] port;
        int          k;

        void'($urandom(SEED));
        addr_i          = '0;
        data_i          = '0;
        io_read_n_i     = 1'b1;
        io_write_n_i    = 1'b1;
        memory_read_n_i = 1'b1;
        aen_n_i         = 1'b0;
        ems_enable_i    = 1'b1;
        ems_frame_i     = 2'd0;
        model_ena       = '0;
        for (k = 0; k < EMS_BANKS; k++) begin
            model_map[k] = '0;
        end
        wait_reset_release();

        // Idle state straight after reset
        mem_address({EMS_FRAME_A, 16'($urandom)}, 1'b0);
        check_value("ems_bank_o", 8'h00, 8'(ems_bank_o));
        check_value("lpt_data_o", 8'hFF, lpt_data_o);

        // Slot and memory window decode
        repeat (32) mem_address({12'h000, 8'($urandom)}, 1'($urandom));
        repeat (16) mem_address({4'hF, 16'($urandom)}, 1'b0);
        repeat (16) mem_address({6'b111011, 14'($urandom)}, 1'b0);
        repeat (32) mem_address(20'($urandom), 1'b0);

        // EMS writes of all three kinds, each read back at once
        for (int i = 0; i < 36; i++) begin
            k     = int'(2'($urandom));
            value = map_value(i % 3);
            io_write(EMS_PORT_BASE + 16'(k), value);
            model_write(k, value);
            io_read(EMS_PORT_BASE + 16'(k), got, valid);
            check_value("data_o", expected_read(k), got);
            check_value("data_valid_o", 8'h01, 8'(valid));
        end

        // Enable every bank, then walk the frames
        for (k = 0; k < EMS_BANKS; k++) begin
            value = map_value(1);
            io_write(EMS_PORT_BASE + 16'(k), value);
            model_write(k, value);
        end
        for (int f = 0; f < 4; f++) begin
            drive_frame(f);
            for (k = 0; k < EMS_BANKS; k++) begin
                mem_address({frame_nibble(f), 2'(k), 14'($urandom)}, 1'b0);
                check_value("ems_bank_o", 8'(4'b0001 << k), 8'(ems_bank_o));
                // Same bank inside a frame that is not selected
                mem_address({frame_nibble((f + 1) % 3), 2'(k), 14'($urandom)}, 1'b0);
                check_value("ems_bank_o", 8'h00, 8'(ems_bank_o));
            end
        end

        // Port writes are ignored while EMS is off
        set_ems_enable(1'b0);
        io_write(EMS_PORT_BASE, 8'hFF);
        io_read(EMS_PORT_BASE, got, valid);
        check_value("data_valid_o", 8'h00, 8'(valid));
        set_ems_enable(1'b1);
        io_read(EMS_PORT_BASE, got, valid);
        check_value("data_o", expected_read(0), got);

        // Printer latch write and read-back
        repeat (8) begin
            port  = LPT_BASE + 16'(3'($urandom));
            value = 8'($urandom);
            io_write(port, value);
            io_read(port, got, valid);
            check_value("data_o", value, got);
            check_value("data_valid_o", 8'h01, 8'(valid));
            check_value("lpt_data_o", value, lpt_data_o);
        end

        @(posedge clock);
        if (dut.u_checker.fail_count != 0) begin
            fail_run("The bound checker reported assertion failures");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- tests/xt_glue_checker.sv
// Concurrent checks on decode windows, LPT latch timing and read strobes.
// Every failure also bumps fail_count, which the testbench watches.
`timescale 1ns/1ps

module xt_glue_checker
    import xt_bus_pkg::*;
#(
    parameter logic [15:0] LPT_BASE = 16'h0378
) (
    input logic                clock,
    input logic                reset,
    input addr_t               addr_i,
    input data_t               bus_data_i,
    input logic                aen_n_i,
    input logic                io_read_n_i,
    input logic                io_write_n_i,
    input logic [IO_SLOTS-1:0] io_cs_n_i,
    input logic                bios_cs_n_i,
    input logic                xtide_cs_n_i,
    input logic                data_valid_i,
    input data_t               lpt_data_i
);

    int   fail_count = 0;
    logic lpt_port;

    // Eight printer ports upward from the base
    assign lpt_port = !aen_n_i && (16'(addr_i[15:0] - LPT_BASE) < 16'd8);

    a_slot_onehot: assert property (@(posedge clock) disable iff (reset)
        (!aen_n_i && addr_i[19:8] == 12'h000) |-> ($onehot(~io_cs_n_i) && !io_cs_n_i[addr_i[7:5]]))
    else begin
        fail_count++;
        $error("I/O slot select is not one-hot at the addressed slot");
    end

    a_slot_idle: assert property (@(posedge clock) disable iff (reset) aen_n_i |-> &io_cs_n_i)
    else begin
        fail_count++;
        $error("I/O slot selected while aen is high");
    end

    a_memory_windows: assert property (@(posedge clock) disable iff (reset)
        ((addr_i >= 20'hF0000) == !bios_cs_n_i) &&
        ((addr_i >= 20'hEC000 && addr_i <= 20'hEFFFF) == !xtide_cs_n_i))
    else begin
        fail_count++;
        $error("BIOS or disk-ROM select does not match its memory window");
    end

    a_valid_needs_read: assert property (@(posedge clock) disable iff (reset)
        data_valid_i |-> !io_read_n_i)
    else begin
        fail_count++;
        $error("data_valid_o high without an I/O read strobe");
    end

    a_lpt_write: assert property (@(posedge clock) disable iff (reset)
        (lpt_port && !io_write_n_i) |=> (lpt_data_i == $past(bus_data_i)))
    else begin
        fail_count++;
        $error("LPT latch did not take the written byte one cycle later");
    end

endmodule

bind xt_glue_top xt_glue_checker #(
    .LPT_BASE (LPT_BASE)
) u_checker (
    .clock        (clock),
    .reset        (reset),
    .addr_i       (addr_i),
    .bus_data_i   (data_i),
    .aen_n_i      (aen_n_i),
    .io_read_n_i  (io_read_n_i),
    .io_write_n_i (io_write_n_i),
    .io_cs_n_i    (io_cs_n_o),
    .bios_cs_n_i  (bios_cs_n_o),
    .xtide_cs_n_i (xtide_cs_n_o),
    .data_valid_i (data_valid_o),
    .lpt_data_i   (lpt_data_o)
);

//--- tests/tb_clock_gen.sv
// Free-running testbench clock and active-high reset held for RESET_CYCLES edges.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

    // Release 1 ns after an edge, away from the clock
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

//--- hdl/xt_glue_top.sv
// Top of the XT address-decode and register glue.
// Port bases are relocatable through parameters; the rest of the map is fixed.
// No handshake: strobes must stay stable for at least one clock.
`timescale 1ns/1ps

module xt_glue_top
    import xt_bus_pkg::*;
#(
    parameter logic [15:0] LPT_BASE      = 16'h0378,
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260
) (
    input  logic                 clock,
    input  logic                 reset,
    input  addr_t                addr_i,
    input  data_t                data_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 memory_read_n_i,
    input  logic                 aen_n_i,
    input  logic                 ems_enable_i,
    input  logic [1:0]           ems_frame_i,
    output logic [IO_SLOTS-1:0]  io_cs_n_o,
    output logic                 bios_cs_n_o,
    output logic                 xtide_cs_n_o,
    output logic [EMS_BANKS-1:0] ems_bank_o,
    output data_t                data_o,
    output logic                 data_valid_o,
    output data_t                lpt_data_o
);

    logic  lpt_sel;
    logic  ems_read_hit;
    data_t ems_read_data;

    bus_decoder #(
        .LPT_BASE (LPT_BASE)
    ) u_bus_decoder (
        .addr_i       (addr_i),
        .aen_n_i      (aen_n_i),
        .io_cs_n_o    (io_cs_n_o),
        .bios_cs_n_o  (bios_cs_n_o),
        .xtide_cs_n_o (xtide_cs_n_o),
        .lpt_sel_o    (lpt_sel)
    );

    ems_mapper #(
        .EMS_PORT_BASE (EMS_PORT_BASE)
    ) u_ems_mapper (
        .clock           (clock),
        .reset           (reset),
        .addr_i          (addr_i),
        .data_i          (data_i),
        .io_write_n_i    (io_write_n_i),
        .io_read_n_i     (io_read_n_i),
        .aen_n_i         (aen_n_i),
        .ems_enable_i    (ems_enable_i),
        .ems_frame_i     (ems_frame_i),
        .ems_bank_o      (ems_bank_o),
        .ems_read_hit_o  (ems_read_hit),
        .ems_read_data_o (ems_read_data)
    );

    readback_mux u_readback_mux (
        .clock           (clock),
        .reset           (reset),
        .data_i          (data_i),
        .io_write_n_i    (io_write_n_i),
        .io_read_n_i     (io_read_n_i),
        .memory_read_n_i (memory_read_n_i),
        .lpt_sel_i       (lpt_sel),
        .ems_read_hit_i  (ems_read_hit),
        .ems_read_data_i (ems_read_data),
        .data_o          (data_o),
        .data_valid_o    (data_valid_o),
        .lpt_data_o      (lpt_data_o)
    );

endmodule

//--- hdl/readback_mux.sv
// Printer data latch and chipset read-back combiner.
// Only EMS and LPT reads are returned; other devices drive the bus themselves.
// An I/O read is ignored while a memory read strobe is also low.
`timescale 1ns/1ps

module readback_mux
    import xt_bus_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  data_t data_i,
    input  logic  io_write_n_i,
    input  logic  io_read_n_i,
    input  logic  memory_read_n_i,
    input  logic  lpt_sel_i,
    input  logic  ems_read_hit_i,
    input  data_t ems_read_data_i,
    output data_t data_o,
    output logic  data_valid_o,
    output data_t lpt_data_o
);

    data_t lpt_data_q;
    logic  io_read_cycle;
    logic  lpt_read;

    // Printer latch idles high like an undriven bus
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_q <= 8'hFF;
        end else if (lpt_sel_i && ~io_write_n_i) begin
            lpt_data_q <= data_i;
        end
    end

    assign lpt_data_o = lpt_data_q;

    assign io_read_cycle = ~io_read_n_i && memory_read_n_i;
    assign lpt_read      = lpt_sel_i && io_read_cycle;

    // EMS takes priority over the printer port
    always_comb begin
        if (ems_read_hit_i && io_read_cycle) begin
            data_o       = ems_read_data_i;
            data_valid_o = 1'b1;
        end else if (lpt_read) begin
            data_o       = lpt_data_q;
            data_valid_o = 1'b1;
        end else begin
            data_o       = '0;
            data_valid_o = 1'b0;
        end
    end

endmodule

//--- hdl/ems_mapper.sv
// EMS page mapper with four map registers at EMS_PORT_BASE..+3.
// EMS_PORT_BASE must be 4-port aligned. Bank hits are combinational
// from the address and follow a register write one clock later.
`timescale 1ns/1ps

module ems_mapper
    import xt_bus_pkg::*;
#(
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260
) (
    input  logic                 clock,
    input  logic                 reset,
    input  addr_t                addr_i,
    input  data_t                data_i,
    input  logic                 io_write_n_i,
    input  logic                 io_read_n_i,
    input  logic                 aen_n_i,
    input  logic                 ems_enable_i,
    input  logic [1:0]           ems_frame_i,
    output logic [EMS_BANKS-1:0] ems_bank_o,
    output logic                 ems_read_hit_o,
    output data_t                ems_read_data_o
);

    localparam int BANK_SEL_W = $clog2(EMS_BANKS);

    pc_addr_u                addr_view;
    logic                    port_hit;
    logic [BANK_SEL_W-1:0]   reg_index;
    logic [3:0]              frame_nibble;

    logic [EMS_MAP_W-1:0]    map_q [EMS_BANKS];
    logic [EMS_BANKS-1:0]    ena_q;

    assign addr_view = addr_i;
    assign reg_index = addr_view.io.port[BANK_SEL_W-1:0];

    assign port_hit = ~aen_n_i && ems_enable_i &&
                      (addr_view.io.port[15:BANK_SEL_W] == EMS_PORT_BASE[15:BANK_SEL_W]);

    // Map register update, values 80h-FEh are ignored
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int k = 0; k < EMS_BANKS; k++) begin
                map_q[k] <= '0;
            end
            ena_q <= '0;
        end else if (port_hit && ~io_write_n_i) begin
            if (data_i == EMS_DISABLE_CODE) begin
                map_q[reg_index] <= '1;
                ena_q[reg_index] <= 1'b0;
            end else if (!data_i[DATA_W-1]) begin
                map_q[reg_index] <= data_i[EMS_MAP_W-1:0];
                ena_q[reg_index] <= 1'b1;
            end
        end
    end

    // Disabled banks read back as FFh
    assign ems_read_hit_o  = port_hit && ~io_read_n_i;
    assign ems_read_data_o = ena_q[reg_index] ? {1'b0, map_q[reg_index]} : EMS_DISABLE_CODE;

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_nibble = EMS_FRAME_A;
            2'd1:    frame_nibble = EMS_FRAME_C;
            default: frame_nibble = EMS_FRAME_D;
        endcase
    end

    // Each enabled register owns one 16 KB bank of the frame
    always_comb begin
        for (int k = 0; k < EMS_BANKS; k++) begin
            ems_bank_o[k] = ena_q[k] &&
                            (addr_view.mem.bank == {frame_nibble, BANK_SEL_W'(k)});
        end
    end

endmodule

//--- hdl/bus_decoder.sv
// Combinational I/O slot, memory window and printer port decode.
// Slot selects cover ports 000h-0FFh only. Memory selects ignore aen.
// LPT_BASE must be 8-port aligned.
`timescale 1ns/1ps

module bus_decoder
    import xt_bus_pkg::*;
#(
    parameter logic [15:0] LPT_BASE = 16'h0378
) (
    input  addr_t               addr_i,
    input  logic                aen_n_i,
    output logic [IO_SLOTS-1:0] io_cs_n_o,
    output logic                bios_cs_n_o,
    output logic                xtide_cs_n_o,
    output logic                lpt_sel_o
);

    localparam int SLOT_SEL_W = $clog2(IO_SLOTS);

    pc_addr_u                addr_view;
    logic                    slot_range;
    logic [SLOT_SEL_W-1:0]   slot_index;

    assign addr_view = addr_i;

    // Motherboard I/O lives in the first 256 ports
    assign slot_range = ~aen_n_i && (addr_view.io.port[9:8] == 2'b00);

    // 32 ports per slot
    assign slot_index = addr_view.io.port[7:5];

    always_comb begin
        io_cs_n_o = '1;
        if (slot_range) begin
            for (int i = 0; i < IO_SLOTS; i++) begin
                if (slot_index == SLOT_SEL_W'(i)) begin
                    io_cs_n_o[i] = 1'b0;
                end
            end
        end
    end

    // 64 KB BIOS window spans four banks
    assign bios_cs_n_o = ~(addr_view.mem.bank[5:2] == BIOS_BANK_HI);

    // 16 KB disk-ROM window is exactly one bank
    assign xtide_cs_n_o = ~(addr_view.mem.bank == XTIDE_BANK);

    // Eight printer ports from the base
    assign lpt_sel_o = ~aen_n_i && (addr_view.io.port[15:3] == LPT_BASE[15:3]);

endmodule

//--- hdl/xt_bus_pkg.sv
// Shared widths, address views and fixed memory-map constants for the XT glue block.
// The memory view assumes 16 KB banks over a 1 MB address space.
package xt_bus_pkg;

    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;
    localparam int EMS_MAP_W = 7;
    localparam int EMS_BANKS = 4;
    localparam int IO_SLOTS  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // I/O cycle view: only the low 16 bits form the port number
    typedef struct packed {
        logic [3:0]  upper;
        logic [15:0] port;
    } io_view_t;

    // Memory cycle view: 16 KB bank index plus offset
    typedef struct packed {
        logic [5:0]  bank;
        logic [13:0] offset;
    } mem_view_t;

    typedef union packed {
        io_view_t  io;
        mem_view_t mem;
    } pc_addr_u;

    // BIOS window F0000h-FFFFFh, compared against bank[5:2]
    localparam logic [3:0] BIOS_BANK_HI = 4'hF;

    // Disk-ROM window EC000h-EFFFFh, one full bank
    localparam logic [5:0] XTIDE_BANK = 6'b111011;

    // EMS page-frame nibbles for A0000h, C0000h and D0000h
    localparam logic [3:0] EMS_FRAME_A = 4'hA;
    localparam logic [3:0] EMS_FRAME_C = 4'hC;
    localparam logic [3:0] EMS_FRAME_D = 4'hD;

    // Writing this value to a map port turns its bank off
    localparam logic [DATA_W-1:0] EMS_DISABLE_CODE = 8'hFF;

endpackage
